/* net_pkg.sv */
//////////////////////////////
// frame field types, header offsets,
// protocol constants and report layout
//////////////////////////////

`default_nettype none

package net_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // protocol values
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP  = 8'd17;
    localparam port_t       DNS_PORT      = 16'd53;
    localparam byte_t       IP_VER_IHL    = 8'h45;

    // ethernet 14 + ipv4 20 + udp 8
    localparam int HDR_BYTES = 42;

    // byte offsets from the start of the frame
    localparam int OFS_SRC_MAC    = 6;
    localparam int OFS_ETH_TYPE   = 12;
    localparam int OFS_IP_VER_IHL = 14;
    localparam int OFS_IP_PROTO   = 23;
    localparam int OFS_SRC_IP     = 26;
    localparam int OFS_DST_PORT   = 36;

    localparam mac_t TRUSTED_MAC = 48'h2020_0000_00aa;

    typedef struct packed {
        mac_t     src_mac;
        ip_addr_t src_ip;
        port_t    dst_port;
    } udp_hdr_t;

    // sent on the line in field order, msb first
    typedef struct packed {
        logic [15:0] txn_id;
        ip_addr_t    src_ip;
    } dns_report_t;

    localparam int REPORT_BYTES = 6;

endpackage

`default_nettype wire

/* uart_pkg.sv */
//////////////////////////////
// UART bit timing and
// character frame length
//////////////////////////////

`default_nettype none

package uart_pkg;

    // short bit time for simulation
    localparam int CLKS_PER_BIT = 16;

    // start, 8 data, stop
    localparam int UART_FRAME_BITS = 10;

endpackage

`default_nettype wire

/* udp_frame_if.sv */
//////////////////////////////
// parsed UDP header plus
// payload byte stream
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface udp_frame_if;

    // header handshake
    logic               hdr_valid;
    logic               hdr_ready;
    net_pkg::udp_hdr_t  hdr;

    // payload stream, header always goes first
    net_pkg::byte_t     tdata;
    logic               tvalid;
    logic               tready;
    logic               tlast;

    modport parser_mp (
        output hdr_valid, hdr, tdata, tvalid, tlast,
        input  hdr_ready, tready
    );

    modport capture_mp (
        input  hdr_valid, hdr, tdata, tvalid, tlast,
        output hdr_ready, tready
    );

endinterface

`default_nettype wire

/* udp_frame_parser.sv */
//////////////////////////////
// ethernet/ipv4/udp header parser
// checks type, version and protocol,
// then passes the payload through
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udp_frame_parser (
    input  logic                clk,
    input  logic                reset,
    input  net_pkg::byte_t      rx_tdata,
    input  logic                rx_tvalid,
    input  logic                rx_tlast,
    output logic                rx_tready,
    udp_frame_if.parser_mp      frame
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_PEND,
        ST_PAYLOAD,
        ST_DROP
    } state_t;

    typedef logic [$clog2(net_pkg::HDR_BYTES)-1:0] hdr_cnt_t;

    state_t             state;
    hdr_cnt_t           hdr_cnt;
    net_pkg::udp_hdr_t  hdr_q;
    logic               rx_fire;
    logic               check_fail;
    logic               at_src_mac;
    logic               at_src_ip;
    logic               at_dst_port;

    assign rx_fire = rx_tvalid && rx_tready;

    // header field windows
    assign at_src_mac  = hdr_cnt >= hdr_cnt_t'(net_pkg::OFS_SRC_MAC) &&
                         hdr_cnt <  hdr_cnt_t'(net_pkg::OFS_SRC_MAC + 6);
    assign at_src_ip   = hdr_cnt >= hdr_cnt_t'(net_pkg::OFS_SRC_IP) &&
                         hdr_cnt <  hdr_cnt_t'(net_pkg::OFS_SRC_IP + 4);
    assign at_dst_port = hdr_cnt >= hdr_cnt_t'(net_pkg::OFS_DST_PORT) &&
                         hdr_cnt <  hdr_cnt_t'(net_pkg::OFS_DST_PORT + 2);

    // mismatch on the byte at the current offset
    always_comb begin
        check_fail = 1'b0;
        case (hdr_cnt)
            hdr_cnt_t'(net_pkg::OFS_ETH_TYPE):
                check_fail = rx_tdata != net_pkg::ETH_TYPE_IPV4[15:8];
            hdr_cnt_t'(net_pkg::OFS_ETH_TYPE + 1):
                check_fail = rx_tdata != net_pkg::ETH_TYPE_IPV4[7:0];
            hdr_cnt_t'(net_pkg::OFS_IP_VER_IHL):
                check_fail = rx_tdata != net_pkg::IP_VER_IHL;
            hdr_cnt_t'(net_pkg::OFS_IP_PROTO):
                check_fail = rx_tdata != net_pkg::IP_PROTO_UDP;
            default:
                check_fail = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_HDR;
            hdr_cnt <= '0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (rx_fire) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        // early end abandons the frame
                        if (rx_tlast) begin
                            hdr_cnt <= '0;
                        end else if (check_fail) begin
                            state   <= ST_DROP;
                            hdr_cnt <= '0;
                        end else if (hdr_cnt == hdr_cnt_t'(net_pkg::HDR_BYTES - 1)) begin
                            state   <= ST_PEND;
                            hdr_cnt <= '0;
                        end
                    end
                end
                ST_PEND: begin
                    if (frame.hdr_ready) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD, ST_DROP: begin
                    if (rx_fire && rx_tlast) begin
                        state <= ST_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

    // shift fields in as they pass
    always_ff @(posedge clk) begin
        if (state == ST_HDR && rx_fire) begin
            if (at_src_mac) begin
                hdr_q.src_mac <= {hdr_q.src_mac[39:0], rx_tdata};
            end
            if (at_src_ip) begin
                hdr_q.src_ip <= {hdr_q.src_ip[23:0], rx_tdata};
            end
            if (at_dst_port) begin
                hdr_q.dst_port <= {hdr_q.dst_port[7:0], rx_tdata};
            end
        end
    end

    always_comb begin
        case (state)
            ST_PEND:    rx_tready = 1'b0;
            ST_PAYLOAD: rx_tready = frame.tready;
            default:    rx_tready = 1'b1;
        endcase
    end

    assign frame.hdr_valid = state == ST_PEND;
    assign frame.hdr       = hdr_q;
    assign frame.tdata     = rx_tdata;
    assign frame.tvalid    = (state == ST_PAYLOAD) && rx_tvalid;
    assign frame.tlast     = rx_tlast;

endmodule

`default_nettype wire

/* dns_query_capture.sv */
//////////////////////////////
// DNS query selection, report
// build and trusted source flag
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dns_query_capture (
    input  logic                    clk,
    input  logic                    reset,
    udp_frame_if.capture_mp         frame,
    output logic                    report_valid,
    output net_pkg::dns_report_t    report,
    output logic                    trusted_src,
    input  logic                    report_ready
);

    logic               keep_q;
    logic [1:0]         pay_cnt;
    logic [15:0]        txn_id_q;
    net_pkg::ip_addr_t  src_ip_q;
    logic               hdr_fire;
    logic               pay_fire;

    // next header waits while a report is pending
    assign frame.hdr_ready = !report_valid;
    assign frame.tready    = 1'b1;

    assign hdr_fire = frame.hdr_valid && frame.hdr_ready;
    assign pay_fire = frame.tvalid && frame.tready;

    always_ff @(posedge clk) begin
        if (reset) begin
            keep_q       <= 1'b0;
            pay_cnt      <= '0;
            report_valid <= 1'b0;
            trusted_src  <= 1'b0;
        end else begin
            if (hdr_fire) begin
                keep_q      <= frame.hdr.dst_port == net_pkg::DNS_PORT;
                trusted_src <= frame.hdr.src_mac == net_pkg::TRUSTED_MAC;
                pay_cnt     <= '0;
            end
            if (pay_fire) begin
                // saturates once the id is complete
                if (pay_cnt != 2'd2) begin
                    pay_cnt <= pay_cnt + 1'b1;
                end
                // tlast on the second byte or later
                if (frame.tlast && keep_q && pay_cnt != 2'd0) begin
                    report_valid <= 1'b1;
                end
            end
            if (report_valid && report_ready) begin
                report_valid <= 1'b0;
            end
        end
    end

    // id high byte first
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            src_ip_q <= frame.hdr.src_ip;
        end
        if (pay_fire && pay_cnt == 2'd0) begin
            txn_id_q[15:8] <= frame.tdata;
        end
        if (pay_fire && pay_cnt == 2'd1) begin
            txn_id_q[7:0] <= frame.tdata;
        end
    end

    assign report = {txn_id_q, src_ip_q};

endmodule

`default_nettype wire

/* uart_report_tx.sv */
//////////////////////////////
// 8N1 UART transmitter for
// the six-byte DNS report
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uart_report_tx (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    report_valid,
    input  net_pkg::dns_report_t    report,
    output logic                    report_ready,
    output logic                    uart_tx
);

    typedef logic [$clog2(uart_pkg::CLKS_PER_BIT)-1:0]    clk_cnt_t;
    typedef logic [$clog2(uart_pkg::UART_FRAME_BITS)-1:0] bit_cnt_t;
    typedef logic [$clog2(net_pkg::REPORT_BYTES)-1:0]     byte_cnt_t;

    logic                                       busy;
    clk_cnt_t                                   clk_cnt;
    bit_cnt_t                                   bit_cnt;
    byte_cnt_t                                  byte_cnt;
    net_pkg::byte_t [net_pkg::REPORT_BYTES-1:0] report_buf;
    logic [uart_pkg::UART_FRAME_BITS-1:0]       frame_q;
    logic                                       load;
    logic                                       bit_end;
    logic                                       char_end;
    logic                                       report_end;

    assign report_ready = !busy;
    assign load         = report_valid && report_ready;

    assign bit_end    = busy && clk_cnt == clk_cnt_t'(uart_pkg::CLKS_PER_BIT - 1);
    assign char_end   = bit_end && bit_cnt == bit_cnt_t'(uart_pkg::UART_FRAME_BITS - 1);
    assign report_end = char_end && byte_cnt == byte_cnt_t'(net_pkg::REPORT_BYTES - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (load) begin
            busy     <= 1'b1;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (busy) begin
            clk_cnt <= clk_cnt + 1'b1;
            if (bit_end) begin
                clk_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (char_end) begin
                bit_cnt  <= '0;
                byte_cnt <= byte_cnt + 1'b1;
            end
            // line goes idle after the last stop bit
            if (report_end) begin
                busy <= 1'b0;
            end
        end
    end

    // stop, data, start; shifted out lsb first
    always_ff @(posedge clk) begin
        if (load) begin
            report_buf <= report;
            frame_q    <= {1'b1, report.txn_id[15:8], 1'b0};
        end else if (char_end) begin
            frame_q    <= {1'b1, report_buf[net_pkg::REPORT_BYTES-2], 1'b0};
            report_buf <= {report_buf[net_pkg::REPORT_BYTES-2:0], 8'h00};
        end else if (bit_end) begin
            frame_q <= {1'b1, frame_q[uart_pkg::UART_FRAME_BITS-1:1]};
        end
    end

    assign uart_tx = busy ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

/* dns_uart_core.sv */
//////////////////////////////
// DNS query receive path top:
// parser, capture, UART report
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dns_uart_core (
    input  logic            clk,
    input  logic            reset,
    input  net_pkg::byte_t  rx_tdata,
    input  logic            rx_tvalid,
    input  logic            rx_tlast,
    output logic            rx_tready,
    output logic            uart_tx,
    output logic            trusted_src
);

    udp_frame_if frame_if ();

    logic                   report_valid;
    logic                   report_ready;
    net_pkg::dns_report_t   report;

    udp_frame_parser udp_frame_parser_i (
        .clk        (clk),
        .reset      (reset),
        .rx_tdata   (rx_tdata),
        .rx_tvalid  (rx_tvalid),
        .rx_tlast   (rx_tlast),
        .rx_tready  (rx_tready),
        .frame      (frame_if.parser_mp)
    );

    dns_query_capture dns_query_capture_i (
        .clk            (clk),
        .reset          (reset),
        .frame          (frame_if.capture_mp),
        .report_valid   (report_valid),
        .report         (report),
        .trusted_src    (trusted_src),
        .report_ready   (report_ready)
    );

    uart_report_tx uart_report_tx_i (
        .clk            (clk),
        .reset          (reset),
        .report_valid   (report_valid),
        .report         (report),
        .report_ready   (report_ready),
        .uart_tx        (uart_tx)
    );

endmodule

`default_nettype wire

/* tb_dns_uart_core.sv */
//////////////////////////////
// testbench for dns_uart_core:
// frame builder, UART decoder,
// reference model, checks, watchdog
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dns_uart_core;

    typedef net_pkg::byte_t byte_q_t[$];

    localparam int REPORT_CYCLES = net_pkg::REPORT_BYTES * uart_pkg::UART_FRAME_BITS *
                                   uart_pkg::CLKS_PER_BIT;
    localparam int QUIET_CYCLES  = REPORT_CYCLES + 2 * uart_pkg::CLKS_PER_BIT;
    localparam int NUM_FRAMES    = 14;
    localparam int FRAME_LEN     = net_pkg::HDR_BYTES + 20;
    // frames x (frame length + one report) x 2 clock periods
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (FRAME_LEN + REPORT_CYCLES) * 2;

    localparam net_pkg::mac_t OTHER_MAC = 48'h0222_3344_5566;

    logic           clk;
    logic           reset;
    net_pkg::byte_t rx_tdata;
    logic           rx_tvalid;
    logic           rx_tlast;
    logic           rx_tready;
    logic           uart_tx;
    logic           trusted_src;

    integer         seed;
    byte_q_t        exp_q;
    byte_q_t        rx_q;
    logic           exp_trusted;
    logic           stall_seen;
    int             errors;
    int             checks;
    int             err_base;
    int             passed;
    int             failed;

    dns_uart_core dns_uart_core_i (
        .clk         (clk),
        .reset       (reset),
        .rx_tdata    (rx_tdata),
        .rx_tvalid   (rx_tvalid),
        .rx_tlast    (rx_tlast),
        .rx_tready   (rx_tready),
        .uart_tx     (uart_tx),
        .trusted_src (trusted_src)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ethernet, ipv4 and udp checks that let a header through
    function automatic logic header_ok(input byte_q_t f);
        if (f.size() <= net_pkg::HDR_BYTES) begin
            return 1'b0;
        end
        return f[net_pkg::OFS_ETH_TYPE] == net_pkg::ETH_TYPE_IPV4[15:8] &&
               f[net_pkg::OFS_ETH_TYPE + 1] == net_pkg::ETH_TYPE_IPV4[7:0] &&
               f[net_pkg::OFS_IP_VER_IHL] == net_pkg::IP_VER_IHL &&
               f[net_pkg::OFS_IP_PROTO] == net_pkg::IP_PROTO_UDP;
    endfunction

    // six report bytes, or nothing for a frame that is not a DNS query
    function automatic byte_q_t expected_report(input byte_q_t f);
        byte_q_t r;
        r = {};
        if (!header_ok(f) || f.size() < net_pkg::HDR_BYTES + 2) begin
            return r;
        end
        if ({f[net_pkg::OFS_DST_PORT], f[net_pkg::OFS_DST_PORT + 1]} != net_pkg::DNS_PORT) begin
            return r;
        end
        r.push_back(f[net_pkg::HDR_BYTES]);
        r.push_back(f[net_pkg::HDR_BYTES + 1]);
        for (int i = 0; i < 4; i++) begin
            r.push_back(f[net_pkg::OFS_SRC_IP + i]);
        end
        return r;
    endfunction

    function automatic logic expected_trusted(input byte_q_t f, input logic prev);
        net_pkg::mac_t mac;
        mac = '0;
        if (!header_ok(f)) begin
            return prev;
        end
        for (int i = 0; i < 6; i++) begin
            mac = {mac[39:0], f[net_pkg::OFS_SRC_MAC + i]};
        end
        return mac == net_pkg::TRUSTED_MAC;
    endfunction

    task automatic build_frame(input net_pkg::mac_t src_mac, input logic [15:0] eth_type,
                               input net_pkg::byte_t ver_ihl, input net_pkg::byte_t proto,
                               input net_pkg::ip_addr_t src_ip, input net_pkg::port_t dst_port,
                               input int pay_len, output byte_q_t f);
        f = {};
        // filler for the fields the DUT ignores
        for (int i = 0; i < net_pkg::HDR_BYTES; i++) begin
            f.push_back(8'(i));
        end
        for (int i = 0; i < 6; i++) begin
            f[i] = 8'hff;
            f[net_pkg::OFS_SRC_MAC + i] = src_mac[47 - 8*i -: 8];
        end
        for (int i = 0; i < 4; i++) begin
            f[net_pkg::OFS_SRC_IP + i] = src_ip[31 - 8*i -: 8];
        end
        f[net_pkg::OFS_ETH_TYPE]     = eth_type[15:8];
        f[net_pkg::OFS_ETH_TYPE + 1] = eth_type[7:0];
        f[net_pkg::OFS_IP_VER_IHL]   = ver_ihl;
        f[net_pkg::OFS_IP_PROTO]     = proto;
        f[net_pkg::OFS_DST_PORT]     = dst_port[15:8];
        f[net_pkg::OFS_DST_PORT + 1] = dst_port[7:0];
        for (int i = 0; i < pay_len; i++) begin
            f.push_back(8'($random(seed)));
        end
    endtask

    // called and returns on a falling edge
    task automatic put_byte(input net_pkg::byte_t b, input logic last);
        logic sent;
        int   waits;
        sent  = 1'b0;
        waits = 0;
        while (($random(seed) & 3) == 0) begin
            rx_tvalid = 1'b0;
            @(negedge clk);
        end
        rx_tdata  = b;
        rx_tvalid = 1'b1;
        rx_tlast  = last;
        while (!sent) begin
            if (!rx_tready) begin
                waits++;
            end
            sent = rx_tready;
            @(negedge clk);
        end
        // one low cycle is the normal header handoff
        if (waits > 1) begin
            stall_seen = 1'b1;
        end
    endtask

    task automatic run_frame(input net_pkg::mac_t src_mac, input logic [15:0] eth_type,
                             input net_pkg::byte_t ver_ihl, input net_pkg::byte_t proto,
                             input net_pkg::ip_addr_t src_ip, input net_pkg::port_t dst_port,
                             input int pay_len, input int cut_len);
        byte_q_t f;
        byte_q_t r;
        build_frame(src_mac, eth_type, ver_ihl, proto, src_ip, dst_port, pay_len, f);
        // cut_len > 0 ends the frame early
        while (cut_len > 0 && f.size() > cut_len) begin
            void'(f.pop_back());
        end
        r = expected_report(f);
        foreach (r[i]) begin
            exp_q.push_back(r[i]);
        end
        exp_trusted = expected_trusted(f, exp_trusted);
        foreach (f[i]) begin
            put_byte(f[i], i == f.size() - 1);
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        checks++;
        if (trusted_src !== exp_trusted) begin
            $display("Error at %0t ns: trusted_src is %b, expected %b",
                     $time, trusted_src, exp_trusted);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // room for any stray report to show up
        repeat (QUIET_CYCLES) @(negedge clk);
        if (errors == err_base) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
    endtask

    // UART decoder sampling each bit in its middle
    initial begin
        net_pkg::byte_t data;
        data = '0;
        while (reset !== 1'b0) begin
            @(negedge clk);
        end
        forever begin
            @(negedge uart_tx);
            repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                $display("start bit on uart_tx did not hold at %0t ns", $time);
                errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
                    data[i] = uart_tx;
                end
                repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    $display("stop bit on uart_tx was low at %0t ns", $time);
                    errors++;
                end
                rx_q.push_back(data);
            end
        end
    end

    // compare decoded bytes with the reference queue
    initial begin
        net_pkg::byte_t got;
        net_pkg::byte_t want;
        forever begin
            while (rx_q.size() == 0) begin
                @(negedge clk);
            end
            got = rx_q.pop_front();
            checks++;
            if (exp_q.size() == 0) begin
                $display("UART sent byte %h at %0t ns when none was expected", got, $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (got !== want) begin
                    $display("Error at %0t ns: UART byte %h, expected %h", $time, got, want);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed        = 32'h5023;
        reset       = 1'b1;
        rx_tdata    = '0;
        rx_tvalid   = 1'b0;
        rx_tlast    = 1'b0;
        exp_trusted = 1'b0;
        stall_seen  = 1'b0;
        errors      = 0;
        checks      = 0;
        passed      = 0;
        failed      = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        err_base = errors;
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hc0a8_0105, 16'd53, 16, 0);
        end_test("dns query");

        err_base = errors;
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hc0a8_0106, 16'd1000, 12, 0);
        end_test("other udp port");

        err_base = errors;
        run_frame(OTHER_MAC, 16'h86dd, 8'h45, 8'd17, 32'h0a00_0001, 16'd53, 10, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd6, 32'h0a00_0002, 16'd53, 10, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h46, 8'd17, 32'h0a00_0003, 16'd53, 10, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'h0a00_0004, 16'd53, 14, 0);
        end_test("bad headers");

        err_base = errors;
        run_frame(net_pkg::TRUSTED_MAC, 16'h0800, 8'h45, 8'd17, 32'h0a01_0001, 16'd5353, 8, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd6, 32'h0a01_0002, 16'd5353, 8, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'h0a01_0003, 16'd5353, 8, 0);
        end_test("trusted source");

        err_base   = errors;
        stall_seen = 1'b0;
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hac10_0001, 16'd53, 18, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hac10_0002, 16'd53, 18, 0);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hac10_0003, 16'd53, 18, 0);
        if (!stall_seen) begin
            $display("rx_tready never held back a byte during back-to-back queries");
            errors++;
        end
        end_test("back to back");

        err_base = errors;
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hc0a8_0a01, 16'd53, 16, 20);
        run_frame(OTHER_MAC, 16'h0800, 8'h45, 8'd17, 32'hc0a8_0a02, 16'd53, 16, 0);
        end_test("short frame");

        $display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
net_pkg.sv
uart_pkg.sv
udp_frame_if.sv
udp_frame_parser.sv
dns_query_capture.sv
uart_report_tx.sv
dns_uart_core.sv
tb_dns_uart_core.sv

/* run.sh */
#!/bin/sh
# compile and run the DNS UART testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f list.f --top-module tb_dns_uart_core -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^No errors$"
